/* verilog/mem_sys_pkg.sv */
// Address and data widths, cache and memory request structs, controller state enum
package mem_sys_pkg;

   // Widths with a meaning of their own
   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;
   typedef logic [4:0]  tag_t;
   typedef logic [7:0]  index_t;
   // Byte offset in a line, bit 0 is always zero
   typedef logic [2:0]  offset_t;

   // Read data arrives this many cycles after the read is issued
   localparam int unsigned mem_read_latency = 2;

   // One access to a cache way
   typedef struct packed {
      logic    en;
      logic    comp;
      logic    write;
      tag_t    tag;
      index_t  index;
      offset_t offset;
      word_t   data;
      logic    valid_in;
   } cache_req_t;

   // What a way reports back for the current access
   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag;
      word_t data;
   } way_status_t;

   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t data;
   } mem_req_t;

   // Write-back and fill states are consecutive so the FSM can step by one
   typedef enum logic [3:0] {
      st_idle,
      st_compare,
      st_wb_0,
      st_wb_1,
      st_wb_2,
      st_wb_3,
      st_fill_req,
      st_fill_0,
      st_fill_1,
      st_fill_2,
      st_fill_3,
      st_final_cmp,
      st_done
   } ctrl_state_t;

endpackage

/* verilog/cache_way.sv */
// One cache way with tag, valid, dirty and four-word data arrays per line
module cache_way
   import mem_sys_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  cache_req_t  req,
   output way_status_t status
);

   localparam int unsigned num_lines = 256;
   localparam int unsigned line_words = 4;

   tag_t                 tag_arr  [num_lines];
   logic                 dirty_arr[num_lines];
   word_t                data_arr [num_lines][line_words];
   logic [num_lines-1:0] valid_arr;

   index_t     idx;
   logic [1:0] word_sel;
   logic       tag_match;
   logic       line_valid;

   assign idx        = req.index;
   // Word within the line, byte bit dropped
   assign word_sel   = req.offset[2:1];
   assign line_valid = valid_arr[idx];
   assign tag_match  = line_valid && (tag_arr[idx] == req.tag);

   // Status follows the current request combinationally
   always_comb begin
      status.hit   = req.en & req.comp & tag_match;
      status.valid = line_valid;
      // Dirty only counts on a valid line
      status.dirty = line_valid & dirty_arr[idx];
      status.tag   = tag_arr[idx];
      status.data  = data_arr[idx][word_sel];
   end

   // Valid bits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_arr <= '0;
      end else if (req.en && req.write && !req.comp) begin
         valid_arr[idx] <= req.valid_in;
      end
   end

   // Tag, dirty and data arrays
   always_ff @(posedge clk) begin
      if (req.en && req.write) begin
         if (!req.comp) begin
            // Line fill writes the tag and leaves the line clean
            tag_arr[idx]            <= req.tag;
            dirty_arr[idx]          <= 1'b0;
            data_arr[idx][word_sel] <= req.data;
         end else if (tag_match) begin
            // Processor write hit
            dirty_arr[idx]          <= 1'b1;
            data_arr[idx][word_sel] <= req.data;
         end
      end
   end

endmodule

/* verilog/four_bank_mem.sv */
// Four-bank word-interleaved main memory with fixed read latency and bank busy counters
module four_bank_mem
   import mem_sys_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  mem_req_t req,
   output word_t    data_out,
   output logic     stall
);

   localparam int unsigned num_banks   = 4;
   localparam int unsigned bank_rows   = 8192;
   // Bank is occupied four cycles, counting the access cycle
   localparam int unsigned busy_cycles = 4;

   word_t      bank_mem[num_banks][bank_rows];
   logic [1:0] busy_cnt[num_banks];
   word_t      rd_pipe [mem_read_latency];

   logic [1:0]  bank;
   logic [12:0] row;
   logic        cmd;
   logic        access;

   // Word interleave, consecutive words go to consecutive banks
   assign bank = req.addr[2:1];
   assign row  = req.addr[15:3];
   assign cmd  = req.rd | req.wr;

   assign stall  = cmd & (busy_cnt[bank] != 2'd0);
   assign access = cmd & ~stall;

   // Memory powers up cleared
   initial begin
      for (int b = 0; b < num_banks; b++) begin
         for (int r = 0; r < bank_rows; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   // Per-bank busy counters
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= 2'd0;
         end
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if (access && (bank == 2'(b))) begin
               busy_cnt[b] <= 2'(busy_cycles - 1);
            end else if (busy_cnt[b] != 2'd0) begin
               busy_cnt[b] <= busy_cnt[b] - 2'd1;
            end
         end
      end
   end

   // Writes land at issue, reads travel down the data pipe
   always_ff @(posedge clk) begin
      if (access && req.wr) begin
         bank_mem[bank][row] <= req.data;
      end
      rd_pipe[0] <= bank_mem[bank][row];
      for (int i = 1; i < mem_read_latency; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign data_out = rd_pipe[mem_read_latency-1];

endmodule

/* verilog/cache_ctrl.sv */
// Cache controller FSM with request registers, victim selection and processor outputs
module cache_ctrl
   import mem_sys_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  addr_t       addr,
   input  word_t       data_in,
   input  logic        rd,
   input  logic        wr,
   output cache_req_t  way0_req,
   output cache_req_t  way1_req,
   input  way_status_t way0_status,
   input  way_status_t way1_status,
   output mem_req_t    mem_req,
   input  word_t       mem_data,
   input  logic        mem_stall,
   output word_t       data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);

   ctrl_state_t state_q;
   ctrl_state_t state_nxt;

   // Request registers
   addr_t addr_q;
   word_t data_q;
   logic  write_q;

   // Way status from the last compare access
   way_status_t stat0_q;
   way_status_t stat1_q;

   logic       way_sel_q;
   logic       victim_q;
   logic [1:0] fill_cnt_q;

   logic        req_ok;
   logic        any_hit;
   logic        vic_way;
   logic        vic_dirty;
   logic [1:0]  step;
   addr_t       cur_addr;
   word_t       cur_data;
   tag_t        sel_tag;
   way_status_t sel_status;
   cache_req_t  acc;
   logic        acc_both;

   assign err    = (rd & wr) | ((rd | wr) & addr[0]);
   assign req_ok = (rd | wr) & ~err;

   assign any_hit = stat0_q.hit | stat1_q.hit;
   // Invalid way first, way 0 before way 1, then the victim flop
   assign vic_way   = !stat0_q.valid ? 1'b0 : (!stat1_q.valid ? 1'b1 : victim_q);
   assign vic_dirty = vic_way ? stat1_q.dirty : stat0_q.dirty;

   assign sel_tag    = way_sel_q ? stat1_q.tag : stat0_q.tag;
   assign sel_status = way_sel_q ? way1_status : way0_status;

   // While idle the request has not been registered yet
   assign cur_addr = (state_q == st_idle) ? addr : addr_q;
   assign cur_data = (state_q == st_idle) ? data_in : data_q;

   // Word number handled by the current write-back or fill state
   always_comb begin
      case (state_q)
         st_wb_1, st_fill_1: step = 2'd1;
         st_wb_2, st_fill_2: step = 2'd2;
         st_wb_3, st_fill_3: step = 2'd3;
         default:            step = 2'd0;
      endcase
   end

   always_comb begin
      acc          = '0;
      acc.tag      = cur_addr[15:11];
      acc.index    = cur_addr[10:3];
      acc.offset   = cur_addr[2:0];
      acc.data     = cur_data;
      acc.valid_in = 1'b1;
      acc_both     = 1'b0;
      mem_req      = '0;
      state_nxt    = state_q;
      case (state_q)
         st_idle: begin
            if (req_ok) begin
               acc.en    = 1'b1;
               acc.comp  = 1'b1;
               acc.write = wr;
               acc_both  = 1'b1;
               state_nxt = st_compare;
            end
         end
         st_compare: begin
            if (any_hit) begin
               state_nxt = st_idle;
            end else if (vic_dirty) begin
               state_nxt = st_wb_0;
            end else begin
               state_nxt = st_fill_req;
            end
         end
         st_wb_0, st_wb_1, st_wb_2, st_wb_3: begin
            // Victim word goes straight to its bank
            acc.en       = 1'b1;
            acc.offset   = {step, 1'b0};
            mem_req.wr   = 1'b1;
            mem_req.addr = {sel_tag, addr_q[10:3], step, 1'b0};
            mem_req.data = sel_status.data;
            state_nxt    = ctrl_state_t'(state_q + 4'd1);
         end
         st_fill_req: begin
            // First reads, one per latency cycle
            mem_req.rd   = 1'b1;
            mem_req.addr = {addr_q[15:3], fill_cnt_q, 1'b0};
            if (fill_cnt_q == 2'(mem_read_latency - 1)) begin
               state_nxt = st_fill_0;
            end
         end
         st_fill_0, st_fill_1, st_fill_2, st_fill_3: begin
            // Word read mem_read_latency cycles ago arrives now
            acc.en     = 1'b1;
            acc.write  = 1'b1;
            acc.offset = {step, 1'b0};
            acc.data   = mem_data;
            if (int'(step) + mem_read_latency < 4) begin
               mem_req.rd   = 1'b1;
               mem_req.addr = {addr_q[15:3], 2'(step + mem_read_latency), 1'b0};
            end
            state_nxt = ctrl_state_t'(state_q + 4'd1);
         end
         st_final_cmp: begin
            acc.en    = 1'b1;
            acc.comp  = 1'b1;
            acc.write = write_q;
            acc_both  = 1'b1;
            state_nxt = st_done;
         end
         st_done: state_nxt = st_idle;
         default: state_nxt = st_idle;
      endcase
      // Busy bank holds the command and the state
      if (mem_stall && (mem_req.rd || mem_req.wr)) begin
         state_nxt = state_q;
      end
   end

   // Compare accesses go to both ways, line accesses to the chosen one
   always_comb begin
      way0_req    = acc;
      way1_req    = acc;
      way0_req.en = acc.en & (acc_both | ~way_sel_q);
      way1_req.en = acc.en & (acc_both | way_sel_q);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= st_idle;
         way_sel_q  <= 1'b0;
         victim_q   <= 1'b0;
         fill_cnt_q <= 2'd0;
      end else begin
         state_q <= state_nxt;
         if (state_q == st_compare) begin
            way_sel_q <= vic_way;
         end
         if (done) begin
            victim_q <= ~victim_q;
         end
         if (state_q == st_fill_req && !mem_stall) begin
            if (fill_cnt_q == 2'(mem_read_latency - 1)) begin
               fill_cnt_q <= 2'd0;
            end else begin
               fill_cnt_q <= fill_cnt_q + 2'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == st_idle && req_ok) begin
         addr_q  <= addr;
         data_q  <= data_in;
         write_q <= wr;
      end
      if (acc_both) begin
         stat0_q <= way0_status;
         stat1_q <= way1_status;
      end
   end

   assign done      = (state_q == st_compare && any_hit) || (state_q == st_done);
   assign cache_hit = (state_q == st_compare) && any_hit;
   // After a miss the final compare hits in the chosen way
   assign data_out  = stat1_q.hit ? stat1_q.data : stat0_q.data;
   assign stall     = (rd | wr) & ~done;

endmodule

/* verilog/mem_system.sv */
// Memory system top level with cache controller, two cache ways and four-bank memory
module mem_system
   import mem_sys_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  addr_t Addr,
   input  word_t DataIn,
   input  logic  Rd,
   input  logic  Wr,
   output word_t DataOut,
   output logic  Done,
   output logic  Stall,
   output logic  CacheHit,
   output logic  err
);

   cache_req_t  way0_req;
   cache_req_t  way1_req;
   way_status_t way0_status;
   way_status_t way1_status;
   mem_req_t    mem_req;
   word_t       mem_data;
   logic        mem_stall;

   cache_ctrl ctrl0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .addr        (Addr),
      .data_in     (DataIn),
      .rd          (Rd),
      .wr          (Wr),
      .way0_req    (way0_req),
      .way1_req    (way1_req),
      .way0_status (way0_status),
      .way1_status (way1_status),
      .mem_req     (mem_req),
      .mem_data    (mem_data),
      .mem_stall   (mem_stall),
      .data_out    (DataOut),
      .done        (Done),
      .stall       (Stall),
      .cache_hit   (CacheHit),
      .err         (err)
   );

   // Two ways of one set-associative cache
   cache_way way0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (way0_req),
      .status (way0_status)
   );

   cache_way way1 (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (way1_req),
      .status (way1_status)
   );

   four_bank_mem mem0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (mem_req),
      .data_out (mem_data),
      .stall    (mem_stall)
   );

endmodule

/* tb/mem_system_tb.sv */
// Random-stimulus testbench for the memory system with a reference cache and memory model
module mem_system_tb
   import mem_sys_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned num_ops      = 2000;
   localparam int unsigned done_timeout = 200;

   // One processor request
   typedef struct packed {
      logic  write;
      addr_t addr;
      word_t data;
   } proc_req_t;

   logic  clk;
   logic  rst_n;
   addr_t Addr;
   word_t DataIn;
   logic  Rd;
   logic  Wr;
   word_t DataOut;
   logic  Done;
   logic  Stall;
   logic  CacheHit;
   logic  err;

   // Reference memory with one entry per word address
   word_t  mem_model[32768];
   // Two-way reference cache
   logic   m_valid[2][256];
   logic   m_dirty[2][256];
   tag_t   m_tag  [2][256];
   word_t  m_data [2][256][4];
   logic   m_victim;

   int   error_count;
   int   request_count;
   int   cold_miss_count;
   int   victim_miss_count;
   int   dirty_evict_count;
   int   hit_count[2];
   logic timed_out;

   initial clk = 1'b0;
   always #4 clk = ~clk;

   mem_system dut0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   // Three sets only, so lines fight over the two ways
   function automatic index_t pick_index(input int unsigned n);
      case (n)
         0:       return 8'h05;
         1:       return 8'h6a;
         default: return 8'hc3;
      endcase
   endfunction

   function automatic tag_t pick_tag(input int unsigned n);
      return 5'(n * 3 + 2);
   endfunction

   function automatic proc_req_t random_req();
      proc_req_t  r;
      logic [1:0] w;
      w       = 2'($urandom % 4);
      r.write = ($urandom % 10) < 4;
      r.addr  = {pick_tag($urandom % 8), pick_index($urandom % 3), w, 1'b0};
      r.data  = 16'($urandom);
      return r;
   endfunction

   task automatic init_model();
      for (int a = 0; a < 32768; a++) begin
         mem_model[a] = '0;
      end
      for (int w = 0; w < 2; w++) begin
         for (int i = 0; i < 256; i++) begin
            m_valid[w][i] = 1'b0;
            m_dirty[w][i] = 1'b0;
         end
      end
      m_victim = 1'b0;
   endtask

   // Applies one request to the model and predicts data and hit
   task automatic model_access(input proc_req_t r, output word_t exp_data,
                               output logic exp_hit);
      tag_t       t;
      index_t     i;
      logic [1:0] w;
      int         way;
      t       = r.addr[15:11];
      i       = r.addr[10:3];
      w       = r.addr[2:1];
      exp_hit = 1'b0;
      way     = 0;
      if (m_valid[0][i] && m_tag[0][i] == t) begin
         exp_hit = 1'b1;
         way     = 0;
      end else if (m_valid[1][i] && m_tag[1][i] == t) begin
         exp_hit = 1'b1;
         way     = 1;
      end
      if (exp_hit) begin
         hit_count[way]++;
      end else begin
         // Invalid way first, then the victim flop
         if (!m_valid[0][i]) begin
            way = 0;
            cold_miss_count++;
         end else if (!m_valid[1][i]) begin
            way = 1;
            cold_miss_count++;
         end else begin
            way = m_victim;
            victim_miss_count++;
         end
         if (m_valid[way][i] && m_dirty[way][i]) begin
            dirty_evict_count++;
            for (int k = 0; k < 4; k++) begin
               mem_model[{m_tag[way][i], i, 2'(k)}] = m_data[way][i][k];
            end
         end
         for (int k = 0; k < 4; k++) begin
            m_data[way][i][k] = mem_model[{t, i, 2'(k)}];
         end
         m_tag[way][i]   = t;
         m_valid[way][i] = 1'b1;
         m_dirty[way][i] = 1'b0;
      end
      exp_data = m_data[way][i][w];
      if (r.write) begin
         m_data[way][i][w] = r.data;
         m_dirty[way][i]   = 1'b1;
      end
      m_victim = ~m_victim;
   endtask

   // Drives one request, waits for Done and checks the response
   task automatic run_request(input proc_req_t r);
      word_t exp_data;
      logic  exp_hit;
      int    cycles;
      logic  got_done;
      model_access(r, exp_data, exp_hit);
      request_count++;
      @(negedge clk);
      Addr   = r.addr;
      DataIn = r.data;
      Rd     = ~r.write;
      Wr     = r.write;
      #1;
      if (err !== 1'b0 || Stall !== 1'b1 || Done !== 1'b0) begin
         $display("Mismatch at %0t: first cycle of %h err=%b Stall=%b Done=%b",
                  $time, r.addr, err, Stall, Done);
         error_count++;
      end
      cycles   = 0;
      got_done = 1'b0;
      while (!got_done && cycles < done_timeout) begin
         @(negedge clk);
         cycles++;
         if (Done === 1'b1) begin
            got_done = 1'b1;
         end else if (Stall !== 1'b1) begin
            $display("Mismatch at %0t: Stall low while waiting on %h", $time, r.addr);
            error_count++;
         end
      end
      if (!got_done) begin
         $display("Error at %0t: no Done within 200 cycles for address %h", $time, r.addr);
         error_count++;
         timed_out = 1'b1;
      end else begin
         if (CacheHit !== exp_hit) begin
            $display("Mismatch at %0t: CacheHit=%b expected %b for %h",
                     $time, CacheHit, exp_hit, r.addr);
            error_count++;
         end
         if (!r.write && DataOut !== exp_data) begin
            $display("Mismatch at %0t: read %h returned %h expected %h",
                     $time, r.addr, DataOut, exp_data);
            error_count++;
         end
         // A hit finishes in the second cycle
         if (exp_hit && (cycles != 1 || Stall !== 1'b0)) begin
            $display("Mismatch at %0t: hit on %h took %0d cycles, Stall=%b at Done",
                     $time, r.addr, cycles + 1, Stall);
            error_count++;
         end
      end
      Rd = 1'b0;
      Wr = 1'b0;
   endtask

   // Illegal request must raise err at once
   task automatic check_err(input addr_t a, input logic rd_v, input logic wr_v);
      @(negedge clk);
      Addr = a;
      Rd   = rd_v;
      Wr   = wr_v;
      #1;
      if (err !== 1'b1) begin
         $display("Mismatch at %0t: err=%b for addr %h Rd=%b Wr=%b", $time, err, a, rd_v, wr_v);
         error_count++;
      end
      @(negedge clk);
      Rd = 1'b0;
      Wr = 1'b0;
      #1;
      if (err !== 1'b0 || Done !== 1'b0) begin
         $display("Mismatch at %0t: err or Done left high after illegal request", $time);
         error_count++;
      end
   endtask

   initial begin
      proc_req_t   req;
      void'($urandom(32'h0ec7e8e7));
      error_count       = 0;
      request_count     = 0;
      cold_miss_count   = 0;
      victim_miss_count = 0;
      dirty_evict_count = 0;
      hit_count[0]      = 0;
      hit_count[1]      = 0;
      timed_out         = 1'b0;
      rst_n             = 1'b0;
      Addr              = '0;
      DataIn            = '0;
      Rd                = 1'b0;
      Wr                = 1'b0;
      init_model();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      if (Done !== 1'b0 || Stall !== 1'b0 || CacheHit !== 1'b0 || err !== 1'b0) begin
         $display("Mismatch at %0t: outputs not low after reset", $time);
         error_count++;
      end
      check_err(16'h0123, 1'b1, 1'b0);
      check_err(16'h0457, 1'b0, 1'b1);
      check_err(16'h0040, 1'b1, 1'b1);
      for (int n = 0; n < num_ops && !timed_out; n++) begin
         req = random_req();
         run_request(req);
      end
      if (!timed_out) begin
         if (victim_miss_count == 0 || dirty_evict_count == 0 ||
             hit_count[0] == 0 || hit_count[1] == 0) begin
            $display("Error: random run missed a hit or miss case, see counts below");
            error_count++;
         end
         // Read every line once more to pull evicted data back from memory
         for (int t = 0; t < 8 && !timed_out; t++) begin
            for (int i = 0; i < 3 && !timed_out; i++) begin
               for (int w = 0; w < 4 && !timed_out; w++) begin
                  req.write = 1'b0;
                  req.addr  = {pick_tag(t), pick_index(i), 2'(w), 1'b0};
                  req.data  = '0;
                  run_request(req);
               end
            end
         end
      end
      $display("Summary: %0d requests, hits %0d/%0d, cold %0d, victim %0d, dirty %0d, errors %0d",
               request_count, hit_count[0], hit_count[1], cold_miss_count,
               victim_miss_count, dirty_evict_count, error_count);
      if (error_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* filelist.f */
verilog/mem_sys_pkg.sv
verilog/cache_way.sv
verilog/four_bank_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
tb/mem_system_tb.sv

/* Bender.yml */
package:
  name: mem_system

dependencies: {}

sources:
  # Design sources in compile order
  - files:
      - verilog/mem_sys_pkg.sv
      - verilog/cache_way.sv
      - verilog/four_bank_mem.sv
      - verilog/cache_ctrl.sv
      - verilog/mem_system.sv
  # Testbench
  - target: test
    files:
      - tb/mem_system_tb.sv
